// File: logic/ula_pkg.sv
package ula_pkg;

	// counter widths
	localparam int HC_W = 9;
	localparam int VC_W = 9;

	// visible area in pixels and lines
	localparam int H_AREA = 256;
	localparam int V_AREA = 192;

	// 128 timing, horizontal in pixels
	localparam int H_RBORDER_128 = 48;
	localparam int H_BLANK1_128 = 28;
	localparam int H_SYNC_128 = 33;
	localparam int H_BLANK2_128 = 43;
	// screen delay is taken off the left border where it is used
	localparam int H_LBORDER_128 = 48;
	localparam int H_TOTAL_128 = H_AREA + H_RBORDER_128 + H_BLANK1_128 + H_SYNC_128
		+ H_BLANK2_128 + H_LBORDER_128;

	// 128 timing, vertical in lines
	localparam int V_BBORDER_128 = 56;
	localparam int V_SYNC_128 = 8;
	localparam int V_TBORDER_128 = 55;
	localparam int V_TOTAL_128 = V_AREA + V_BBORDER_128 + V_SYNC_128 + V_TBORDER_128;

	// pentagon timing, horizontal in pixels
	localparam int H_RBORDER_PENT = 56;
	localparam int H_BLANK1_PENT = 16;
	localparam int H_SYNC_PENT = 33;
	localparam int H_BLANK2_PENT = 15;
	localparam int H_LBORDER_PENT = 72;
	localparam int H_TOTAL_PENT = H_AREA + H_RBORDER_PENT + H_BLANK1_PENT + H_SYNC_PENT
		+ H_BLANK2_PENT + H_LBORDER_PENT;

	// pentagon timing, vertical in lines
	localparam int V_BBORDER_PENT = 56;
	localparam int V_SYNC_PENT = 8;
	localparam int V_TBORDER_PENT = 64;
	localparam int V_TOTAL_PENT = V_AREA + V_BBORDER_PENT + V_SYNC_PENT + V_TBORDER_PENT;

	// interrupt window, line and pixel column range
	localparam int INT_V_128 = 248;
	localparam int INT_H_FROM_128 = 2;
	localparam int INT_H_TO_128 = 65;
	localparam int INT_V_PENT = 239;
	localparam int INT_H_FROM_PENT = 336;
	localparam int INT_H_TO_PENT = 408;

	// a port matches when every address bit under its mask is low
	localparam logic [15:0] PORT_FE = 16'h0001;
	localparam logic [15:0] PORT_7FFD = 16'h8002;
	// 7ffd also needs a14 or a13 high
	localparam logic [15:0] PORT_7FFD_HI = 16'h6000;
	localparam logic [15:0] PORT_KEMPSTON = 16'h00e0;

	typedef struct packed {
		logic [HC_W-1:0] hc;
		logic [VC_W-1:0] vc;
		logic pix_phase;
		logic hsync;
		logic vsync;
		logic blank;
		logic screen_load;
		logic screen_show;
		logic screen_update;
		logic border_update;
		logic line_end;
	} raster_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] data;
		logic rd_n;
		logic wr_n;
		logic iorq_n;
		logic m1_n;
	} cpu_bus_t;

	typedef struct packed {
		logic rd;
		logic page;
		logic [14:0] addr;
	} vram_req_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic i;
		logic hsync;
		logic vsync;
		logic csync;
	} video_t;

	typedef struct packed {
		logic [2:0] border;
		logic vbank;
	} io_state_t;

endpackage

// File: logic/raster_timing.sv
`timescale 1ns/1ps

module raster_timing #(
	parameter int SCREEN_DELAY = 8
) (
	input logic clk14,
	input logic rst_n,
	input logic timing_sel,
	output ula_pkg::raster_t raster
);

	localparam int HW = ula_pkg::HC_W;
	localparam int VW = ula_pkg::VC_W;

	localparam logic [HW-1:0] H_AREA_W = HW'(ula_pkg::H_AREA);
	localparam logic [VW-1:0] V_AREA_W = VW'(ula_pkg::V_AREA);
	localparam logic [HW-1:0] SHOW_FROM = HW'(SCREEN_DELAY);
	localparam logic [HW-1:0] SHOW_TO = HW'(ula_pkg::H_AREA + SCREEN_DELAY);

	// 128 boundaries, right border widened by the screen delay
	localparam int HB_128_I = ula_pkg::H_AREA + ula_pkg::H_RBORDER_128 + SCREEN_DELAY;
	localparam int HS_128_I = HB_128_I + ula_pkg::H_BLANK1_128;
	localparam logic [HW:0] H_LAST_128 = (HW+1)'(2 * ula_pkg::H_TOTAL_128 - 1);
	localparam logic [HW-1:0] H_TOT_128 = HW'(ula_pkg::H_TOTAL_128);
	localparam logic [HW-1:0] HB_128 = HW'(HB_128_I);
	localparam logic [HW-1:0] HS_128 = HW'(HS_128_I);
	localparam logic [HW-1:0] HE_128 = HW'(HS_128_I + ula_pkg::H_SYNC_128);
	localparam logic [HW-1:0] HBE_128 =
		HW'(ula_pkg::H_TOTAL_128 - (ula_pkg::H_LBORDER_128 - SCREEN_DELAY));
	localparam logic [VW-1:0] V_LAST_128 = VW'(ula_pkg::V_TOTAL_128 - 1);
	localparam logic [VW-1:0] VS_128 = VW'(ula_pkg::V_AREA + ula_pkg::V_BBORDER_128);
	localparam logic [VW-1:0] VE_128 =
		VW'(ula_pkg::V_AREA + ula_pkg::V_BBORDER_128 + ula_pkg::V_SYNC_128);

	// pentagon boundaries
	localparam int HB_PENT_I = ula_pkg::H_AREA + ula_pkg::H_RBORDER_PENT + SCREEN_DELAY;
	localparam int HS_PENT_I = HB_PENT_I + ula_pkg::H_BLANK1_PENT;
	localparam logic [HW:0] H_LAST_PENT = (HW+1)'(2 * ula_pkg::H_TOTAL_PENT - 1);
	localparam logic [HW-1:0] H_TOT_PENT = HW'(ula_pkg::H_TOTAL_PENT);
	localparam logic [HW-1:0] HB_PENT = HW'(HB_PENT_I);
	localparam logic [HW-1:0] HS_PENT = HW'(HS_PENT_I);
	localparam logic [HW-1:0] HE_PENT = HW'(HS_PENT_I + ula_pkg::H_SYNC_PENT);
	localparam logic [HW-1:0] HBE_PENT =
		HW'(ula_pkg::H_TOTAL_PENT - (ula_pkg::H_LBORDER_PENT - SCREEN_DELAY));
	localparam logic [VW-1:0] V_LAST_PENT = VW'(ula_pkg::V_TOTAL_PENT - 1);
	localparam logic [VW-1:0] VS_PENT = VW'(ula_pkg::V_AREA + ula_pkg::V_BBORDER_PENT);
	localparam logic [VW-1:0] VE_PENT =
		VW'(ula_pkg::V_AREA + ula_pkg::V_BBORDER_PENT + ula_pkg::V_SYNC_PENT);

	// half-pixel counter, hc is its upper part
	logic [HW:0] hc0;
	logic [VW-1:0] vc;
	logic [HW-1:0] hc;
	logic [HW:0] h_last;
	logic [HW-1:0] h_total;
	logic [HW-1:0] h_blank_from;
	logic [HW-1:0] h_sync_from;
	logic [HW-1:0] h_sync_to;
	logic [HW-1:0] h_blank_to;
	logic [VW-1:0] v_last;
	logic [VW-1:0] v_sync_from;
	logic [VW-1:0] v_sync_to;
	logic v_sync_zone;
	logic cell_start;

	// timing_sel high picks the 128 timing
	always_comb begin
		if (timing_sel) begin
			h_last = H_LAST_128;
			h_total = H_TOT_128;
			h_blank_from = HB_128;
			h_sync_from = HS_128;
			h_sync_to = HE_128;
			h_blank_to = HBE_128;
			v_last = V_LAST_128;
			v_sync_from = VS_128;
			v_sync_to = VE_128;
		end else begin
			h_last = H_LAST_PENT;
			h_total = H_TOT_PENT;
			h_blank_from = HB_PENT;
			h_sync_from = HS_PENT;
			h_sync_to = HE_PENT;
			h_blank_to = HBE_PENT;
			v_last = V_LAST_PENT;
			v_sync_from = VS_PENT;
			v_sync_to = VE_PENT;
		end
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (raster.line_end) begin
			hc0 <= '0;
			if (vc == v_last)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end else begin
			hc0 <= hc0 + 1'b1;
		end
	end

	assign hc = hc0[HW:1];
	assign v_sync_zone = vc >= v_sync_from && vc < v_sync_to;
	// first half-pixel of each 8-pixel cell
	assign cell_start = hc0[3:0] == 4'b0000;

	assign raster.hc = hc;
	assign raster.vc = vc;
	assign raster.pix_phase = hc0[0];
	assign raster.line_end = hc0 == h_last;
	assign raster.hsync = hc >= h_sync_from && hc < h_sync_to;
	assign raster.vsync = v_sync_zone;
	assign raster.blank = v_sync_zone || (hc >= h_blank_from && hc < h_blank_to);
	assign raster.screen_load = vc < V_AREA_W && hc < H_AREA_W;
	assign raster.screen_show = vc < V_AREA_W && hc >= SHOW_FROM && hc < SHOW_TO;
	assign raster.screen_update = vc < V_AREA_W && hc <= H_AREA_W && hc != '0 && cell_start;
	// pentagon follows the border colour every clk14, 128 once per cell
	assign raster.border_update = !raster.screen_show && (!timing_sel || cell_start);

	hc_in_line: assert property (@(posedge clk14) disable iff (!rst_n) hc < h_total);

endmodule

// File: logic/screen_fetch.sv
`timescale 1ns/1ps

module screen_fetch #(
	parameter int SCREEN_DELAY = 8
) (
	input logic clk14,
	input logic rst_n,
	input ula_pkg::raster_t raster,
	input ula_pkg::io_state_t io,
	input logic flash,
	output ula_pkg::vram_req_t vram_req,
	input logic [7:0] vram_data,
	output ula_pkg::video_t video
);

	logic fetch_en;
	logic attr_read;
	logic bitmap_read;
	logic [14:0] bitmap_addr;
	logic [14:0] attr_addr;
	logic [7:0] attr_next;
	logic [7:0] bitmap_next;
	logic [7:0] attr;
	logic [7:0] bitmap;
	logic pixel;
	logic [2:0] grb;

	// no video memory reads in the first cycle out of reset
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			fetch_en <= 1'b0;
		else
			fetch_en <= 1'b1;
	end

	// spectrum interleaved bitmap layout, attributes after it at 0x1800
	assign bitmap_addr = {2'b10, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};
	assign attr_addr = {5'b10110, raster.vc[7:3], raster.hc[7:3]};

	assign vram_req.rd = raster.screen_load & fetch_en;
	assign vram_req.page = io.vbank;
	assign vram_req.addr = raster.pix_phase ? bitmap_addr : attr_addr;

	// attribute on even half-pixels, bitmap on odd
	assign attr_read = vram_req.rd & ~raster.pix_phase;
	assign bitmap_read = vram_req.rd & raster.pix_phase;

	always_ff @(posedge clk14) begin
		if (attr_read)
			attr_next <= vram_data;
		else if (!raster.screen_load)
			attr_next <= 8'hff;
		if (bitmap_read)
			bitmap_next <= vram_data;
	end

	// working attribute and pixel shifter
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			attr <= '0;
			bitmap <= '0;
		end else begin
			if (raster.border_update)
				attr <= {2'b00, io.border, 3'b000};
			else if (raster.screen_update)
				attr <= attr_next;
			if (raster.screen_update)
				bitmap <= bitmap_next;
			else if (raster.pix_phase)
				bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	assign pixel = bitmap[7];
	// flash swaps ink and paper
	assign grb = (pixel ^ (attr[7] & flash)) ? attr[2:0] : attr[5:3];

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			video <= '0;
			video.csync <= 1'b1;
		end else if (raster.pix_phase) begin
			if (raster.blank) begin
				video.r <= 1'b0;
				video.g <= 1'b0;
				video.b <= 1'b0;
				video.i <= 1'b0;
			end else begin
				video.g <= grb[2];
				video.r <= grb[1];
				video.b <= grb[0];
				// bright black stays black
				video.i <= attr[6] & (|grb);
			end
			video.hsync <= raster.hsync;
			video.vsync <= raster.vsync;
			video.csync <= ~(raster.vsync ^ raster.hsync);
		end
	end

	rd_in_window: assert property (@(posedge clk14) disable iff (!rst_n)
		vram_req.rd |-> raster.screen_load);

endmodule

// File: logic/frame_int.sv
`timescale 1ns/1ps

module frame_int (
	input logic clk14,
	input logic rst_n,
	input logic timing_sel,
	input ula_pkg::raster_t raster,
	output logic n_int,
	output logic flash
);

	localparam int HW = ula_pkg::HC_W;
	localparam int VW = ula_pkg::VC_W;

	localparam logic [VW-1:0] INT_V_128 = VW'(ula_pkg::INT_V_128);
	localparam logic [HW-1:0] INT_FROM_128 = HW'(ula_pkg::INT_H_FROM_128);
	localparam logic [HW-1:0] INT_TO_128 = HW'(ula_pkg::INT_H_TO_128);
	localparam logic [VW-1:0] INT_V_PENT = VW'(ula_pkg::INT_V_PENT);
	localparam logic [HW-1:0] INT_FROM_PENT = HW'(ula_pkg::INT_H_FROM_PENT);
	localparam logic [HW-1:0] INT_TO_PENT = HW'(ula_pkg::INT_H_TO_PENT);

	logic in_window;
	logic n_int0;
	logic n_int_q;
	logic [4:0] frame_cnt;

	assign in_window = timing_sel ?
		raster.vc == INT_V_128 && raster.hc >= INT_FROM_128 && raster.hc <= INT_TO_128 :
		raster.vc == INT_V_PENT && raster.hc >= INT_FROM_PENT && raster.hc <= INT_TO_PENT;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_int0 <= 1'b1;
			n_int <= 1'b1;
			n_int_q <= 1'b1;
			frame_cnt <= '0;
		end else begin
			n_int0 <= ~in_window;
			n_int <= n_int0;
			n_int_q <= n_int;
			// one count per interrupt
			if (n_int_q && !n_int)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	assign flash = frame_cnt[4];

endmodule

// File: logic/io_ports.sv
`timescale 1ns/1ps

module io_ports (
	input logic clk14,
	input logic rst_n,
	input ula_pkg::cpu_bus_t bus,
	input logic [4:0] kd,
	input logic tape_in,
	input logic [6:0] joy_n,
	output ula_pkg::io_state_t io,
	output logic [7:0] data_out,
	output logic data_oe,
	output logic beeper,
	output logic tape_out
);

	logic io_req;
	logic fe_hit;
	logic p7ffd_hit;
	logic kempston_hit;
	logic read_hit;
	logic kempston_sel;
	logic [4:0] port_fe;
	logic vbank;
	logic lock;
	logic [7:0] fe_data;
	logic [7:0] kempston_data;

	// iorq with m1 low is an interrupt acknowledge, not a port access
	assign io_req = !bus.iorq_n && bus.m1_n;

	assign fe_hit = io_req && (bus.addr & ula_pkg::PORT_FE) == '0;
	assign p7ffd_hit = io_req && (bus.addr & ula_pkg::PORT_7FFD) == '0
		&& (bus.addr & ula_pkg::PORT_7FFD_HI) != '0;
	assign kempston_hit = io_req && (bus.addr & ula_pkg::PORT_KEMPSTON) == '0;

	assign read_hit = !bus.rd_n && (fe_hit || kempston_hit);

	// fe keeps border, tape out and beeper bits only
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			port_fe <= '0;
		else if (fe_hit && !bus.wr_n)
			port_fe <= bus.data[4:0];
	end

	// 7ffd is frozen once its lock bit is written
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			vbank <= 1'b0;
			lock <= 1'b0;
		end else if (p7ffd_hit && !bus.wr_n && !lock) begin
			vbank <= bus.data[3];
			lock <= bus.data[5];
		end
	end

	// read strobe registered, bus driven one cycle after the request
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			data_oe <= 1'b0;
			kempston_sel <= 1'b0;
		end else begin
			data_oe <= read_hit;
			kempston_sel <= !bus.rd_n && kempston_hit;
		end
	end

	assign fe_data = {1'b1, tape_in, 1'b1, kd};
	// joy_n is b3, b2, b1, up, down, left, right from the top
	assign kempston_data = {1'b0, ~joy_n};
	assign data_out = kempston_sel ? kempston_data : fe_data;

	assign io.border = port_fe[2:0];
	assign io.vbank = vbank;
	assign beeper = port_fe[4];
	assign tape_out = port_fe[3] ^ tape_in;

	oe_after_read: assert property (@(posedge clk14) disable iff (!rst_n)
		$rose(data_oe) |-> $past(read_hit));

endmodule

// File: logic/zx_ula.sv
`timescale 1ns/1ps

module zx_ula (
	input logic clk14,
	input logic rst_n,
	input logic timing_sel,
	input ula_pkg::cpu_bus_t bus,
	input logic [4:0] kd,
	input logic tape_in,
	input logic [6:0] joy_n,
	output ula_pkg::vram_req_t vram_req,
	input logic [7:0] vram_data,
	output ula_pkg::video_t video,
	output logic n_int,
	output logic [7:0] data_out,
	output logic data_oe,
	output logic beeper,
	output logic tape_out
);

	// pixels the picture lags behind the fetch
	localparam int SCREEN_DELAY = 8;

	ula_pkg::raster_t raster;
	ula_pkg::io_state_t io;
	logic flash;

	raster_timing #(
		.SCREEN_DELAY(SCREEN_DELAY)
	) u_raster (
		.clk14(clk14),
		.rst_n(rst_n),
		.timing_sel(timing_sel),
		.raster(raster)
	);

	screen_fetch #(
		.SCREEN_DELAY(SCREEN_DELAY)
	) u_fetch (
		.clk14(clk14),
		.rst_n(rst_n),
		.raster(raster),
		.io(io),
		.flash(flash),
		.vram_req(vram_req),
		.vram_data(vram_data),
		.video(video)
	);

	frame_int u_int (
		.clk14(clk14),
		.rst_n(rst_n),
		.timing_sel(timing_sel),
		.raster(raster),
		.n_int(n_int),
		.flash(flash)
	);

	io_ports u_io (
		.clk14(clk14),
		.rst_n(rst_n),
		.bus(bus),
		.kd(kd),
		.tape_in(tape_in),
		.joy_n(joy_n),
		.io(io),
		.data_out(data_out),
		.data_oe(data_oe),
		.beeper(beeper),
		.tape_out(tape_out)
	);

endmodule

// File: include/ula_tb_tasks.svh
`ifndef ULA_TB_TASKS_SVH
`define ULA_TB_TASKS_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

task automatic next_rand(output logic [31:0] r);
	rng = xorshift(rng);
	r = rng;
endtask

// a timeout stops all later waits and checks, the run then ends as failed
task automatic timeout(input string what);
	if (!timed_out)
		$display("timeout: no %s within the cycle limit", what);
	timed_out = 1;
endtask

task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
	if (!timed_out && got !== exp) begin
		errors++;
		$display("error at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
	end
endtask

task automatic check_addr(input string what, input logic [14:0] got, input logic [14:0] exp);
	if (!timed_out && got !== exp) begin
		errors++;
		$display("error at time %0t: %s is %04h, expected %04h", $time, what, got, exp);
	end
endtask

// colour as g, r, b like the attribute bits
task automatic check_colour(input string what, input ula_pkg::video_t got,
		input logic [2:0] exp_grb, input logic exp_i);
	if (!timed_out && ({got.g, got.r, got.b} !== exp_grb || got.i !== exp_i)) begin
		errors++;
		$display("error at time %0t: %s colour %0d bright %0b, expected %0d bright %0b",
			$time, what, {got.g, got.r, got.b}, got.i, exp_grb, exp_i);
	end
endtask

task automatic check_count(input string what, input int got, input int exp);
	if (!timed_out && got != exp) begin
		errors++;
		$display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
	end
endtask

function automatic logic sig_level(input int which);
	case (which)
		0: return video.hsync;
		1: return video.vsync;
		default: return data_oe;
	endcase
endfunction

function automatic string sig_name(input int which);
	case (which)
		0: return "hsync edge";
		1: return "vsync edge";
		default: return "data_oe";
	endcase
endfunction

// cycles counts the clocks until the rising edge
task automatic wait_rise(input int which, input int limit, output int cycles);
	logic prev;
	bit seen;
	cycles = 0;
	seen = 0;
	prev = sig_level(which);
	while (!seen && !timed_out && cycles < limit) begin
		@(negedge clk14);
		cycles++;
		seen = sig_level(which) && !prev;
		prev = sig_level(which);
	end
	if (!seen)
		timeout(sig_name(which));
endtask

// called right after a rising edge, the edge cycle counts as one
task automatic count_high(input int which, input int limit, output int cycles);
	cycles = 1;
	while (!timed_out && sig_level(which) && cycles <= limit) begin
		@(negedge clk14);
		if (sig_level(which))
			cycles++;
	end
	if (cycles > limit)
		timeout({"falling ", sig_name(which)});
endtask

task automatic io_write(input logic [15:0] a, input logic [7:0] d);
	@(posedge clk14);
	bus.addr <= a;
	bus.data <= d;
	bus.iorq_n <= 1'b0;
	bus.wr_n <= 1'b0;
	@(posedge clk14);
	bus.iorq_n <= 1'b1;
	bus.wr_n <= 1'b1;
endtask

task automatic io_read(input logic [15:0] a, output logic [7:0] d);
	int n;
	bit seen;
	seen = 0;
	d = 8'h00;
	@(posedge clk14);
	bus.addr <= a;
	bus.iorq_n <= 1'b0;
	bus.rd_n <= 1'b0;
	for (n = 0; n < 8 && !seen && !timed_out; n++) begin
		@(negedge clk14);
		if (data_oe) begin
			d = data_out;
			seen = 1;
		end
	end
	if (!seen)
		timeout("data_oe during a port read");
	@(posedge clk14);
	bus.iorq_n <= 1'b1;
	bus.rd_n <= 1'b1;
endtask

`endif

// File: bench/ula_tb.sv
`timescale 1ns/1ps

module ula_tb;

	localparam logic [31:0] SEED = 32'hc6e0fe9c;
	localparam int LINE_LIMIT = 2000;
	localparam int FRAME_LIMIT = 400000;

	logic clk14;
	logic rst_n;
	logic timing_sel;
	ula_pkg::cpu_bus_t bus;
	logic [4:0] kd;
	logic tape_in;
	logic [6:0] joy_n;
	ula_pkg::vram_req_t vram_req;
	logic [7:0] vram_data;
	ula_pkg::video_t video;
	logic n_int;
	logic [7:0] data_out;
	logic data_oe;
	logic beeper;
	logic tape_out;

	logic [31:0] rng;
	logic [2:0] border;
	int line_len;
	int errors;
	int err_start;
	int tests_run;
	int tests_failed;
	bit timed_out;

	zx_ula DUT (
		.clk14(clk14),
		.rst_n(rst_n),
		.timing_sel(timing_sel),
		.bus(bus),
		.kd(kd),
		.tape_in(tape_in),
		.joy_n(joy_n),
		.vram_req(vram_req),
		.vram_data(vram_data),
		.video(video),
		.n_int(n_int),
		.data_out(data_out),
		.data_oe(data_oe),
		.beeper(beeper),
		.tape_out(tape_out)
	);

	always #2 clk14 = ~clk14;

	`include "ula_tb_tasks.svh"

	// bitmap is all ones, attributes are a hash of the address with flash off
	function automatic logic [7:0] vram_byte(input logic [14:0] a);
		logic [31:0] s;
		// attributes sit at 0x5800, the bitmap below them
		if (a[12:11] != 2'b11)
			return 8'hff;
		s = xorshift(SEED ^ {17'd0, a});
		s = xorshift(s);
		return {1'b0, s[6:0]};
	endfunction

	always_comb vram_data = vram_byte(vram_req.addr);

	// interleaved bitmap row order, attribute rows of 8 lines
	function automatic logic [14:0] expected_addr(input logic [7:0] y, input int k);
		logic [4:0] col;
		col = k[8:4];
		if (k[0])
			return {2'b10, y[7:6], y[2:0], y[5:3], col};
		return {5'b10110, y[7:3], col};
	endfunction

	task automatic apply_reset(input logic sel);
		@(posedge clk14);
		rst_n <= 1'b0;
		timing_sel <= sel;
		line_len = sel ? 912 : 896;
		repeat (2) @(posedge clk14);
		rst_n <= 1'b1;
	endtask

	task automatic start_test();
		err_start = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != err_start || timed_out) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_start);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	task automatic test_raster(input string tag);
		int c;
		int lines;
		int n;
		int frame_lines;
		int cs_low;
		logic prev_hs;
		logic prev_vs;
		bit done;
		start_test();
		frame_lines = timing_sel ? 311 : 320;
		wait_rise(0, LINE_LIMIT, c);
		wait_rise(0, LINE_LIMIT, c);
		check_count("hsync period", c, line_len);
		count_high(0, LINE_LIMIT, c);
		check_count("hsync width", c, 66);
		wait_rise(1, FRAME_LIMIT, c);
		lines = 0;
		cs_low = 0;
		done = 0;
		prev_hs = video.hsync;
		prev_vs = 1'b1;
		for (n = 0; n < FRAME_LIMIT && !done && !timed_out; n++) begin
			@(negedge clk14);
			if (video.hsync && !prev_hs)
				lines++;
			if (!video.csync)
				cs_low++;
			if (video.vsync && !prev_vs)
				done = 1;
			prev_hs = video.hsync;
			prev_vs = video.vsync;
		end
		if (!done)
			timeout("vsync while counting lines");
		check_count("lines per frame", lines, frame_lines);
		// csync is low where exactly one sync is high, the vsync lines hold 8 hsync pulses
		check_count("csync low cycles", cs_low, 8 * line_len + 66 * (frame_lines - 16));
		finish_test({"raster ", tag});
	endtask

	task automatic test_interrupt(input string tag);
		int c;
		int falls;
		int low;
		int n;
		logic prev_int;
		logic prev_vs;
		bit done;
		start_test();
		wait_rise(1, FRAME_LIMIT, c);
		falls = 0;
		low = 0;
		done = 0;
		prev_int = n_int;
		prev_vs = 1'b1;
		for (n = 0; n < FRAME_LIMIT && !done && !timed_out; n++) begin
			@(negedge clk14);
			if (!n_int && prev_int)
				falls++;
			if (!n_int)
				low++;
			if (video.vsync && !prev_vs)
				done = 1;
			prev_int = n_int;
			prev_vs = video.vsync;
		end
		if (!done)
			timeout("vsync while watching the interrupt");
		check_count("interrupts per frame", falls, 1);
		check_count("interrupt width", low, timing_sel ? 128 : 146);
		finish_test({"interrupt ", tag});
	endtask

	task automatic test_border(input string tag);
		logic [31:0] r;
		int c;
		int gap;
		int hits;
		int n;
		logic prev_vs;
		bit done;
		start_test();
		next_rand(r);
		border = 3'(r % 7) + 3'd1;
		io_write(16'h00fe, {5'd0, border});
		wait_rise(1, FRAME_LIMIT, c);
		gap = 0;
		hits = 0;
		done = 0;
		prev_vs = 1'b1;
		for (n = 0; n < FRAME_LIMIT && !done && !timed_out; n++) begin
			@(negedge clk14);
			gap = vram_req.rd ? 0 : gap + 1;
			if (gap >= line_len && !video.vsync && {video.g, video.r, video.b} != 3'd0) begin
				hits++;
				check_colour("border", video, border, 1'b0);
			end
			if (video.vsync && !prev_vs)
				done = 1;
			prev_vs = video.vsync;
		end
		if (!done)
			timeout("vsync in the border test");
		if (done && hits == 0) begin
			errors++;
			$display("the border colour never showed outside the screen");
		end
		finish_test({"border ", tag});
	endtask

	task automatic test_screen(input string tag);
		int c;
		int pos;
		int row;
		int line;
		int n;
		int o;
		logic prev_rd;
		logic prev_vs;
		logic [7:0] attr;
		bit done;
		start_test();
		wait_rise(1, FRAME_LIMIT, c);
		pos = 0;
		row = -1;
		line = 0;
		done = 0;
		prev_rd = 1'b0;
		prev_vs = 1'b1;
		for (n = 0; n < FRAME_LIMIT && !done && !timed_out; n++) begin
			@(negedge clk14);
			pos = (vram_req.rd && !prev_rd) ? 0 : pos + 1;
			if (vram_req.rd) begin
				if (!prev_rd)
					row = line;
				check_addr("vram address", vram_req.addr, expected_addr(line[7:0], pos));
			end else if (prev_rd) begin
				line++;
			end
			// each cell shows 8 pixels after its reads, behind the output register
			o = pos - 16;
			if (row >= 0 && o >= 0 && o < 512 && o % 16 >= 2) begin
				// all bitmap bits set, so the whole cell is ink
				attr = vram_byte(expected_addr(row[7:0], o & 32'h1f0));
				check_colour("screen", video, attr[2:0], attr[6] & (|attr[2:0]));
			end
			if (video.vsync && !prev_vs)
				done = 1;
			prev_rd = vram_req.rd;
			prev_vs = video.vsync;
		end
		if (!done)
			timeout("vsync in the screen test");
		check_count("screen lines fetched", line, 192);
		finish_test({"screen ", tag});
	endtask

	task automatic test_ports();
		logic [31:0] r;
		logic [7:0] d;
		start_test();
		next_rand(r);
		@(posedge clk14);
		kd <= r[4:0];
		tape_in <= r[5];
		joy_n <= r[12:6];
		io_read(16'h00fe, d);
		check_byte("port fe read", d, {1'b1, r[5], 1'b1, r[4:0]});
		io_read(16'h001f, d);
		check_byte("kempston read", d, {1'b0, ~r[12:6]});
		io_write(16'h00fe, {3'd0, r[14], r[13], border});
		@(negedge clk14);
		check_byte("beeper", {7'd0, beeper}, {7'd0, r[14]});
		check_byte("tape out", {7'd0, tape_out}, {7'd0, r[13] ^ r[5]});
		finish_test("ports");
	endtask

	task automatic test_7ffd();
		start_test();
		io_write(16'h7ffd, 8'h08);
		@(negedge clk14);
		check_byte("page after 7ffd write", {7'd0, vram_req.page}, 8'd1);
		io_write(16'h7ffd, 8'h28);
		io_write(16'h7ffd, 8'h00);
		@(negedge clk14);
		check_byte("page with lock set", {7'd0, vram_req.page}, 8'd1);
		finish_test("port 7ffd lock");
	endtask

	initial begin
		int a;
		clk14 = 1'b0;
		rst_n = 1'b0;
		timing_sel = 1'b1;
		bus.addr = 16'hffff;
		bus.data = 8'h00;
		bus.rd_n = 1'b1;
		bus.wr_n = 1'b1;
		bus.iorq_n = 1'b1;
		bus.m1_n = 1'b1;
		kd = 5'h1f;
		tape_in = 1'b0;
		joy_n = 7'h7f;
		rng = SEED;
		border = 3'd0;
		line_len = 912;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 0;
		for (a = 0; a < 2; a++) begin
			apply_reset(a == 0);
			test_raster(a == 0 ? "128" : "pentagon");
			test_interrupt(a == 0 ? "128" : "pentagon");
			test_border(a == 0 ? "128" : "pentagon");
			test_screen(a == 0 ? "128" : "pentagon");
		end
		test_ports();
		test_7ffd();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
logic/ula_pkg.sv
logic/raster_timing.sv
logic/screen_fetch.sv
logic/frame_int.sv
logic/io_ports.sv
logic/zx_ula.sv
bench/ula_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module ula_tb \
	-Mdir obj_dir \
	-f vlog.f

./obj_dir/Vula_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
